/* design/csrShadow.sv */
//////////////////////////////////////////////////////////////////////
// Machine CSR shadows
// Masked merge of RVFI write and read data per CSR
// Shadow registers with a write-back flag on value change
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "rvviDefs.svh"

module csrShadow import rvviTracePkg::*; (
    input  logic                             rvvi,
    input  logic                             rstN_i,
    input  logic                             retireValid_i,
    input  csrPort_t                         csrIn_i [`NUM_CSR],
    output logic [`NUM_CSR-1:0][`XLEN-1:0]   csrValue_o,
    output logic [`NUM_CSR-1:0]              csrWb_o
);

    logic [`NUM_CSR-1:0][`XLEN-1:0] mergedValue;
    logic [`NUM_CSR-1:0]            valueChanged;

    ///////////////////////////////////////////////////////////////////
    // Per-CSR merge and compare
    ///////////////////////////////////////////////////////////////////
    for (genvar gCsr = 0; gCsr < `NUM_CSR; gCsr++) begin : genCsr
        localparam csrIdx_e Idx = csrIdx_e'(gCsr);

        // Written bits under the mask, read bits elsewhere
        assign mergedValue[Idx] = (csrIn_i[Idx].wdata & csrIn_i[Idx].wmask) |
                                  (csrIn_i[Idx].rdata & ~csrIn_i[Idx].wmask);

        // Compare against the shadow from the previous retirement
        assign valueChanged[Idx] = (mergedValue[Idx] != csrValue_o[Idx]);
    end

    ///////////////////////////////////////////////////////////////////
    // Shadow and flag registers
    ///////////////////////////////////////////////////////////////////
    always_ff @(posedge rvvi) begin
        if (!rstN_i) begin
            csrValue_o <= '0;
            csrWb_o    <= '0;
        end else if (retireValid_i) begin
            csrValue_o <= mergedValue;
            csrWb_o    <= valueChanged;
        end else begin
            csrWb_o    <= '0;
        end
    end

endmodule

/* design/gprWriteback.sv */
//////////////////////////////////////////////////////////////////////
// GPR write-back view
// Decodes the RVFI destination ports into per-register data
// and a written-register bitmap, registered on each retirement
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "rvviDefs.svh"

module gprWriteback import rvviTracePkg::*; (
    input  logic                                 rvvi,
    input  logic                                 rstN_i,
    input  logic                                 retireValid_i,
    input  rdWrite_t                             rdWrite_i [`NUM_RD_PORTS],
    output logic [`NUM_GPR-1:0][`XLEN-1:0]       xWdata_o,
    output logic [`NUM_GPR-1:0]                  xWb_o
);

    logic [`NUM_GPR-1:0][`XLEN-1:0] wdataNext;
    logic [`NUM_GPR-1:0]            wbNext;

    // Later ports override earlier ones, x0 stays untouched
    always_comb begin
        wdataNext = '0;
        wbNext    = '0;
        for (int r = 1; r < `NUM_GPR; r++) begin
            for (int p = 0; p < `NUM_RD_PORTS; p++) begin
                if (rdWrite_i[p].addr == `REG_ADDR_W'(r)) begin
                    wdataNext[r] = rdWrite_i[p].data;
                    wbNext[r]    = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge rvvi) begin
        if (!rstN_i) begin
            xWdata_o <= '0;
            xWb_o    <= '0;
        end else if (retireValid_i) begin
            xWdata_o <= wdataNext;
            xWb_o    <= wbNext;
        end else begin
            // Data holds, bitmap only marks retiring cycles
            xWb_o    <= '0;
        end
    end

endmodule

/* design/netEventQueue.sv */
//////////////////////////////////////////////////////////////////////
// Watched-net change detector
// Four-entry circular event queue with valid/ready output
// Sticky overflow flag for events dropped on a full queue
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "rvviDefs.svh"

module netEventQueue import rvviNetPkg::*; (
    input  logic      rvvi,
    input  logic      rstN_i,
    input  netSnap_t  snap_i,
    output netEvent_t netEvent_o,
    output logic      netValid_o,
    input  logic      netReady_i,
    output logic      netOverflow_o
);

    localparam int PTR_W = $clog2(`NET_FIFO_DEPTH);

    netSnap_t         prevSnap;
    netSnap_t         changed;
    netEvent_t        queueMem [`NET_FIFO_DEPTH];
    logic [PTR_W-1:0] wrPtr;
    logic [PTR_W-1:0] rdPtr;
    logic [PTR_W:0]   count;
    logic             full;
    logic             push;
    logic             pop;

    ///////////////////////////////////////////////////////////////////
    // Change detection
    ///////////////////////////////////////////////////////////////////
    assign changed = snap_i ^ prevSnap;
    assign full    = (count == (PTR_W+1)'(`NET_FIFO_DEPTH));
    assign push    = (|changed) && !full;
    assign pop     = netValid_o && netReady_i;

    always_ff @(posedge rvvi) begin
        if (!rstN_i) begin
            prevSnap      <= '0;
            netOverflow_o <= 1'b0;
        end else begin
            prevSnap <= snap_i;
            // Change seen with no room left
            if ((|changed) && full) begin
                netOverflow_o <= 1'b1;
            end
        end
    end

    ///////////////////////////////////////////////////////////////////
    // Circular queue
    ///////////////////////////////////////////////////////////////////
    always_ff @(posedge rvvi) begin
        if (push) begin
            queueMem[wrPtr] <= '{snap: snap_i, changed: changed};
        end
    end

    always_ff @(posedge rvvi) begin
        if (!rstN_i) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Head entry stays put until the consumer takes it
    assign netValid_o = (count != '0);
    assign netEvent_o = queueMem[rdPtr];

endmodule

/* design/rvfiToRvvi.sv */
//////////////////////////////////////////////////////////////////////
// RVFI to RVVI trace converter top level
// Retirement register, snapshot assembly of the watched nets
// GPR, CSR and net-event paths
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "rvviDefs.svh"

module rvfiToRvvi import rvviTracePkg::*, rvviNetPkg::*; (
    input  logic                            rvvi,
    input  logic                            rstN_i,
    input  rvfiRetire_t                     retire_i,
    input  rdWrite_t                        rdWrite_i [`NUM_RD_PORTS],
    input  csrPort_t                        csrIn_i [`NUM_CSR],
    input  logic [`IRQ_W-1:0]               irq_i,
    input  logic                            debugReq_i,
    output rvfiRetire_t                     trace_o,
    output logic [`NUM_GPR-1:0][`XLEN-1:0]  xWdata_o,
    output logic [`NUM_GPR-1:0]             xWb_o,
    output logic [`NUM_CSR-1:0][`XLEN-1:0]  csrValue_o,
    output logic [`NUM_CSR-1:0]             csrWb_o,
    output netEvent_t                       netEvent_o,
    output logic                            netValid_o,
    input  logic                            netReady_i,
    output logic                            netOverflow_o
);

    netSnap_t netSnap;

    // Retirement record, one cycle behind RVFI
    always_ff @(posedge rvvi) begin
        if (!rstN_i) begin
            trace_o.valid <= 1'b0;
        end else begin
            trace_o <= retire_i;
        end
    end

    ///////////////////////////////////////////////////////////////////
    // Watched nets in netId_e order
    ///////////////////////////////////////////////////////////////////
    always_comb begin
        netSnap              = '0;
        netSnap[NET_MSW]     = irq_i[`IRQ_MSW];
        netSnap[NET_MTIMER]  = irq_i[`IRQ_MTIMER];
        netSnap[NET_MEXT]    = irq_i[`IRQ_MEXT];
        for (int i = 0; i < `NUM_LOCAL_IRQ; i++) begin
            netSnap[int'(NET_LOCAL0) + i] = irq_i[`IRQ_LOCAL_BASE + i];
        end
        netSnap[NET_HALTREQ] = debugReq_i;
    end

    gprWriteback u_gprWriteback (
        .rvvi          (rvvi),
        .rstN_i        (rstN_i),
        .retireValid_i (retire_i.valid),
        .rdWrite_i     (rdWrite_i),
        .xWdata_o      (xWdata_o),
        .xWb_o         (xWb_o)
    );

    csrShadow u_csrShadow (
        .rvvi          (rvvi),
        .rstN_i        (rstN_i),
        .retireValid_i (retire_i.valid),
        .csrIn_i       (csrIn_i),
        .csrValue_o    (csrValue_o),
        .csrWb_o       (csrWb_o)
    );

    netEventQueue u_netEventQueue (
        .rvvi          (rvvi),
        .rstN_i        (rstN_i),
        .snap_i        (netSnap),
        .netEvent_o    (netEvent_o),
        .netValid_o    (netValid_o),
        .netReady_i    (netReady_i),
        .netOverflow_o (netOverflow_o)
    );

endmodule

/* design/rvviDefs.svh */
//////////////////////////////////////////////////////////////////////
// Build-time widths and counts for the RVFI to RVVI converter
// Interrupt line positions of the watched nets
// Depth of the net-event queue
//////////////////////////////////////////////////////////////////////
`ifndef RVVI_DEFS_SVH
`define RVVI_DEFS_SVH

// Datapath and register file
`define XLEN           32
`define NUM_GPR        32
`define REG_ADDR_W     5
`define NUM_RD_PORTS   2
`define NUM_CSR        8

// Core interrupt vector layout
`define IRQ_W          32
`define IRQ_MSW        3
`define IRQ_MTIMER     7
`define IRQ_MEXT       11
`define IRQ_LOCAL_BASE 16
`define NUM_LOCAL_IRQ  16

// Pending net events held for the consumer
`define NET_FIFO_DEPTH 4

`endif

/* design/rvviNetPkg.sv */
//////////////////////////////////////////////////////////////////////
// Types for the watched-net path
// Net position enum, snapshot vector and change event struct
//////////////////////////////////////////////////////////////////////
`include "rvviDefs.svh"

package rvviNetPkg;

    // Three machine interrupts, the local lines and haltreq
    localparam int NUM_NET = `NUM_LOCAL_IRQ + 4;

    typedef enum logic [4:0] {
        NET_MSW     = 5'd0,
        NET_MTIMER  = 5'd1,
        NET_MEXT    = 5'd2,
        NET_LOCAL0  = 5'd3,
        NET_LOCAL15 = 5'd18,
        NET_HALTREQ = 5'd19
    } netId_e;

    // Level of every watched net, bit positions follow netId_e
    typedef logic [NUM_NET-1:0] netSnap_t;

    // New levels plus the bits that moved
    typedef struct packed {
        netSnap_t snap;
        netSnap_t changed;
    } netEvent_t;

endpackage

/* design/rvviTracePkg.sv */
//////////////////////////////////////////////////////////////////////
// Types for the retirement trace path
// Privilege mode and shadowed CSR index enums
// Retirement record, destination write and CSR report structs
//////////////////////////////////////////////////////////////////////
`include "rvviDefs.svh"

package rvviTracePkg;

    typedef enum logic [1:0] {
        PRIV_USER       = 2'b00,
        PRIV_SUPERVISOR = 2'b01,
        PRIV_MACHINE    = 2'b11
    } privMode_e;

    // Slot of each CSR in the shadow arrays
    typedef enum logic [2:0] {
        CSR_MSTATUS  = 3'd0,
        CSR_MIE      = 3'd1,
        CSR_MTVEC    = 3'd2,
        CSR_MSCRATCH = 3'd3,
        CSR_MEPC     = 3'd4,
        CSR_MCAUSE   = 3'd5,
        CSR_MIP      = 3'd6,
        CSR_MINSTRET = 3'd7
    } csrIdx_e;

    // One retired instruction as reported on RVFI
    typedef struct packed {
        logic              valid;
        logic [63:0]       order;
        logic [31:0]       insn;
        logic              trap;
        logic              intr;
        privMode_e         mode;
        logic [`XLEN-1:0]  pc;
    } rvfiRetire_t;

    typedef struct packed {
        logic [`REG_ADDR_W-1:0] addr;
        logic [`XLEN-1:0]       data;
    } rdWrite_t;

    typedef struct packed {
        logic [`XLEN-1:0] rdata;
        logic [`XLEN-1:0] wdata;
        logic [`XLEN-1:0] wmask;
    } csrPort_t;

endpackage

/* run.sh */
#!/bin/bash
# Build and run the RVFI to RVVI testbench with Verilator
set -eo pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module rvfiToRvviTb
./obj_dir/VrvfiToRvviTb | tee sim.log

if grep -q "TEST FAILED" sim.log; then
    exit 1
fi
if ! grep -q "TEST PASSED" sim.log; then
    exit 1
fi

/* sim.f */
+incdir+design
design/rvviTracePkg.sv
design/rvviNetPkg.sv
design/gprWriteback.sv
design/csrShadow.sv
design/netEventQueue.sv
design/rvfiToRvvi.sv
sim/rvfiToRvvi_props.sv
sim/rvfiToRvviTb.sv

/* sim/rvfiInput.txt */
# R valid order insn trap intr mode pc rd0 data0 rd1 data1 csr rdata wdata wmask xWb csrWb
# N irq debugReq, E snap changed, O overflow valid, D drain, T test name; values in hex
T trace
R 1 1 00000013 0 0 3 80000000 00 0 00 0 0 0 0 0 0 00
R 1 2 30200073 1 0 1 80000004 00 0 00 0 0 0 0 0 0 00
R 1 ffffffff00000003 00000073 0 1 0 80000008 00 0 00 0 0 0 0 0 0 00
R 0 4 00000000 0 0 3 8000000c 00 0 00 0 0 0 0 0 0 00
T gpr
R 1 5 00a00093 0 0 3 80000010 01 0000000a 02 00000014 0 0 0 0 00000006 00
R 1 6 00500293 0 0 3 80000014 05 11111111 05 22222222 0 0 0 0 00000020 00
R 1 7 01f00f93 0 0 3 80000018 00 deadbeef 1f 0000001f 0 0 0 0 80000000 00
R 0 8 00000000 0 0 3 8000001c 00 0 00 0 0 0 0 0 0 00
T csr
R 1 9 30002073 0 0 3 80000020 00 0 00 0 0 00001800 00000008 00000008 0 01
R 1 a 30002073 0 0 3 80000024 00 0 00 0 0 00001808 00000000 00000000 0 00
R 1 b 30529073 0 0 3 80000028 00 0 00 0 2 00000000 80000100 ffffffff 0 04
R 1 c b0002073 0 0 3 8000002c 00 0 00 0 7 00000010 ffffffff 0000000f 0 80
R 1 d 30043073 0 0 3 80000030 00 0 00 0 0 00001808 00000000 00000008 0 01
R 0 e 00000000 0 0 3 80000034 00 0 00 0 0 00001808 00000000 00000008 0 00
T netEvents
N 00000008 0
N 00000088 0
N 00010088 1
N 80010880 1
N 80010880 0
E 00001 00001
E 00003 00002
E 8000b 80008
E c000e 40005
O 1 1
D
O 1 0
T unwatched
N 80010881 0
O 1 0
N 80010891 0
O 1 0

/* sim/rvfiToRvviTb.sv */
//////////////////////////////////////////////////////////////////////
// Testbench for the RVFI to RVVI converter
// Reads cycle vectors, drives retirements and watched nets
// Checks trace, GPR, CSR and net-event outputs
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "rvviDefs.svh"

module rvfiToRvviTb import rvviTracePkg::*, rvviNetPkg::*; ();

    localparam int DRAIN_TIMEOUT = 50;

    logic                           rvvi = 1'b0;
    logic                           rstN_i;
    rvfiRetire_t                    retire_i;
    rdWrite_t                       rdWrite_i [`NUM_RD_PORTS];
    csrPort_t                       csrIn_i [`NUM_CSR];
    logic [`IRQ_W-1:0]              irq_i;
    logic                           debugReq_i;
    rvfiRetire_t                    trace_o;
    logic [`NUM_GPR-1:0][`XLEN-1:0] xWdata_o;
    logic [`NUM_GPR-1:0]            xWb_o;
    logic [`NUM_CSR-1:0][`XLEN-1:0] csrValue_o;
    logic [`NUM_CSR-1:0]            csrWb_o;
    netEvent_t                      netEvent_o;
    logic                           netValid_o;
    logic                           netReady_i;
    logic                           netOverflow_o;

    // Expected results of the retirement driven one cycle back
    logic                           pending;
    rvfiRetire_t                    expTrace;
    logic [`NUM_GPR-1:0][`XLEN-1:0] expGprData;
    logic [`NUM_GPR-1:0]            expGprMask;
    logic [`NUM_GPR-1:0]            expXwb;
    logic [2:0]                     expCsrIdx;
    logic [`XLEN-1:0]               expCsrValue;
    logic [`NUM_CSR-1:0]            expCsrWb;
    netEvent_t                      expEvents [$];

    logic [63:0] fld [17];
    int          errCount;
    int          testErrBase;
    int          testsRun;
    int          testsFailed;
    string       testName;

    rvfiToRvvi u_rvfiToRvvi (.*);

    always #50 rvvi = ~rvvi;

    task automatic reportMismatch(input string sigName, input logic [135:0] got,
                                  input logic [135:0] exp);
        $display("Fail %s: got %0h, expected %0h", sigName, got, exp);
        errCount++;
    endtask

    task automatic closeTest();
        if (testName != "") begin
            testsRun++;
            if (errCount == testErrBase) begin
                $display("Test %s: pass", testName);
            end else begin
                testsFailed++;
                $display("Test %s: fail, %0d errors", testName, errCount - testErrBase);
            end
        end
        testName    = "";
        testErrBase = errCount;
    endtask

    task automatic checkRetire();
        if (pending) begin
            if (trace_o !== expTrace) begin
                reportMismatch("trace_o", 136'(trace_o), 136'(expTrace));
            end
            if (xWb_o !== expXwb) begin
                reportMismatch("xWb_o", 136'(xWb_o), 136'(expXwb));
            end
            if (csrWb_o !== expCsrWb) begin
                reportMismatch("csrWb_o", 136'(csrWb_o), 136'(expCsrWb));
            end
            // Data only moves on a retirement
            if (expTrace.valid) begin
                for (int r = 0; r < `NUM_GPR; r++) begin
                    if (expGprMask[r] && xWdata_o[r] !== expGprData[r]) begin
                        reportMismatch($sformatf("xWdata_o[%0d]", r),
                                       136'(xWdata_o[r]), 136'(expGprData[r]));
                    end
                end
                if (csrValue_o[expCsrIdx] !== expCsrValue) begin
                    reportMismatch($sformatf("csrValue_o[%0d]", expCsrIdx),
                                   136'(csrValue_o[expCsrIdx]), 136'(expCsrValue));
                end
            end
            pending = 1'b0;
        end
    endtask

    task automatic flushRetire();
        if (pending) begin
            @(posedge rvvi);
            @(negedge rvvi);
            checkRetire();
        end
    endtask

    task automatic driveRetire();
        rvfiRetire_t rec;
        logic [4:0]  a0;
        logic [4:0]  a1;
        logic [2:0]  idx;
        rec.valid = fld[0][0];
        rec.order = fld[1];
        rec.insn  = fld[2][31:0];
        rec.trap  = fld[3][0];
        rec.intr  = fld[4][0];
        rec.mode  = privMode_e'(fld[5][1:0]);
        rec.pc    = fld[6][31:0];
        a0        = fld[7][4:0];
        a1        = fld[9][4:0];
        idx       = fld[11][2:0];
        @(posedge rvvi);
        retire_i     <= rec;
        rdWrite_i[0] <= '{addr: a0, data: fld[8][31:0]};
        rdWrite_i[1] <= '{addr: a1, data: fld[10][31:0]};
        csrIn_i[idx] <= '{rdata: fld[12][31:0], wdata: fld[13][31:0],
                          wmask: fld[14][31:0]};
        @(negedge rvvi);
        checkRetire();
        // Second port wins and x0 is never written
        pending    = 1'b1;
        expTrace   = rec;
        expGprMask = '0;
        if (a0 != 5'd0) begin
            expGprData[a0] = fld[8][31:0];
            expGprMask[a0] = 1'b1;
        end
        if (a1 != 5'd0) begin
            expGprData[a1] = fld[10][31:0];
            expGprMask[a1] = 1'b1;
        end
        expXwb      = fld[15][31:0];
        expCsrIdx   = idx;
        // Each mask bit picks the written bit over the read bit
        for (int b = 0; b < `XLEN; b++) begin
            expCsrValue[b] = fld[14][b] ? fld[13][b] : fld[12][b];
        end
        expCsrWb    = fld[16][7:0];
    endtask

    task automatic drainEvents();
        netEvent_t   expEvt;
        logic [31:0] rnd;
        int          idleCycles;
        idleCycles = 0;
        while (expEvents.size() > 0 && idleCycles < DRAIN_TIMEOUT) begin
            rnd = $urandom();
            @(posedge rvvi);
            netReady_i <= rnd[0];
            @(negedge rvvi);
            idleCycles++;
            // Event taken at the coming edge
            if (netValid_o && netReady_i) begin
                expEvt = expEvents.pop_front();
                if (netEvent_o !== expEvt) begin
                    reportMismatch("netEvent_o", 136'(netEvent_o), 136'(expEvt));
                end
                idleCycles = 0;
            end
        end
        if (expEvents.size() > 0) begin
            $display("Error: timed out waiting for netValid_o, %0d events missing",
                     expEvents.size());
            errCount++;
            expEvents.delete();
        end
    endtask

    initial begin
        int    fd;
        int    nFields;
        string line;
        void'($urandom(32'h1e25_356d));
        rstN_i     = 1'b0;
        retire_i   = '0;
        irq_i      = '0;
        debugReq_i = 1'b0;
        netReady_i = 1'b0;
        for (int i = 0; i < `NUM_RD_PORTS; i++) begin
            rdWrite_i[i] = '0;
        end
        for (int i = 0; i < `NUM_CSR; i++) begin
            csrIn_i[i] = '0;
        end
        pending     = 1'b0;
        errCount    = 0;
        testErrBase = 0;
        testsRun    = 0;
        testsFailed = 0;

        repeat (8) @(posedge rvvi);
        rstN_i <= 1'b1;
        @(negedge rvvi);
        testName = "reset";
        if (trace_o.valid !== 1'b0) begin
            reportMismatch("trace_o.valid", 136'(trace_o.valid), 136'(0));
        end
        if (xWb_o !== '0) begin
            reportMismatch("xWb_o", 136'(xWb_o), 136'(0));
        end
        if (csrWb_o !== '0) begin
            reportMismatch("csrWb_o", 136'(csrWb_o), 136'(0));
        end
        if (netValid_o !== 1'b0) begin
            reportMismatch("netValid_o", 136'(netValid_o), 136'(0));
        end
        if (netOverflow_o !== 1'b0) begin
            reportMismatch("netOverflow_o", 136'(netOverflow_o), 136'(0));
        end
        closeTest();

        ////////////////////////////////////////////////////////////////////
        // One vector file line per cycle or command
        ////////////////////////////////////////////////////////////////////
        fd = $fopen("sim/rvfiInput.txt", "r");
        if (fd == 0) begin
            $display("Error: cannot open the vector file sim/rvfiInput.txt");
            errCount++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() < 2 || line[0] == "#") begin
                    continue;
                end
                if (line[0] != "R") begin
                    flushRetire();
                end
                case (line[0])
                    "T": begin
                        closeTest();
                        void'($sscanf(line, "T %s", testName));
                    end
                    "R": begin
                        nFields = $sscanf(line,
                            "R %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                            fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6],
                            fld[7], fld[8], fld[9], fld[10], fld[11], fld[12],
                            fld[13], fld[14], fld[15], fld[16]);
                        if (nFields != 17) begin
                            $display("Error: retirement line has %0d fields", nFields);
                            errCount++;
                        end else begin
                            driveRetire();
                        end
                    end
                    "N": begin
                        void'($sscanf(line, "N %h %h", fld[0], fld[1]));
                        @(posedge rvvi);
                        irq_i      <= fld[0][31:0];
                        debugReq_i <= fld[1][0];
                    end
                    "E": begin
                        void'($sscanf(line, "E %h %h", fld[0], fld[1]));
                        expEvents.push_back(netEvent_t'{snap: fld[0][19:0],
                                                        changed: fld[1][19:0]});
                    end
                    "O": begin
                        void'($sscanf(line, "O %h %h", fld[0], fld[1]));
                        @(posedge rvvi);
                        @(negedge rvvi);
                        if (netOverflow_o !== fld[0][0]) begin
                            reportMismatch("netOverflow_o", 136'(netOverflow_o),
                                           136'(fld[0][0]));
                        end
                        if (netValid_o !== fld[1][0]) begin
                            reportMismatch("netValid_o", 136'(netValid_o),
                                           136'(fld[1][0]));
                        end
                    end
                    "D": drainEvents();
                    default: begin
                        $display("Error: unknown vector line kind in the input file");
                        errCount++;
                    end
                endcase
            end
            flushRetire();
            $fclose(fd);
        end
        closeTest();

        $display("Tests run: %0d, tests failed: %0d, failed checks: %0d",
                 testsRun, testsFailed, errCount);
        if (errCount == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* sim/rvfiToRvvi_props.sv */
//////////////////////////////////////////////////////////////////////
// Concurrent checks bound into the converter top level
// Net-event hold under stall, sticky overflow, trace reset
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module rvfiToRvvi_props import rvviNetPkg::*; (
    input logic      rvvi,
    input logic      rstN_i,
    input logic      traceValid_i,
    input netEvent_t netEvent_i,
    input logic      netValid_i,
    input logic      netReady_i,
    input logic      netOverflow_i
);

    // Stalled head event stays put
    holdOnStall: assert property (@(posedge rvvi) disable iff (!rstN_i)
        netValid_i && !netReady_i |=> netValid_i && $stable(netEvent_i))
        else $error("net event moved while the consumer stalled");

    stickyOverflow: assert property (@(posedge rvvi) disable iff (!rstN_i)
        netOverflow_i |=> netOverflow_i)
        else $error("overflow flag dropped outside reset");

    traceResetLow: assert property (@(posedge rvvi)
        !rstN_i |=> !traceValid_i)
        else $error("trace valid high right after reset");

endmodule

bind rvfiToRvvi rvfiToRvvi_props u_props (
    .rvvi          (rvvi),
    .rstN_i        (rstN_i),
    .traceValid_i  (trace_o.valid),
    .netEvent_i    (netEvent_o),
    .netValid_i    (netValid_o),
    .netReady_i    (netReady_i),
    .netOverflow_i (netOverflow_o)
);
